// ==== hw/corr_cfg_pkg.sv ====
package corr_cfg_pkg;

	localparam int LAG_SUB_W = 3;               // One lag sub-field
	localparam int LAG_SUBS  = 4;               // Sub-fields per lag word
	localparam int LAG_W     = LAG_SUB_W * LAG_SUBS;
	localparam int NIB_W     = 4;               // Half of a per-input byte field

	// Lag word of one input, sub-field 0 in the low bits
	typedef logic [LAG_W-1:0] lag_t;

	typedef logic [2*NIB_W-1:0] nib8_t;         // Test, LED and voltage fields
	typedef logic [7:0] line_t;                 // Current input line
	typedef logic [3:0] code_t;                 // Baud rate and divider codes

	// Global settings shared by every input
	typedef struct packed {
		logic  integrating;
		logic  external_clock;
		logic  timestamp_reset;                 // Set out of reset
		logic  extra_commands;                  // Length bank and upper nibbles
		code_t clock_divider;
		code_t baud_rate;
		line_t current_line;                    // Built two bits at a time
	} corr_flags_t;

endpackage

// ==== hw/corr_cmd_pkg.sv ====
package corr_cmd_pkg;

	// Low nibble of a host command byte
	typedef enum logic [3:0] {
		CLEAR          = 4'd0,
		SET_LINE       = 4'd1,
		SET_LEDS       = 4'd2,
		SET_BAUD_RATE  = 4'd3,
		SET_DELAY      = 4'd4,                  // 4 to 7, low bits pick sub-field
		SET_FREQ_DIV   = 4'd8,
		SET_VOLTAGE    = 4'd9,
		ENABLE_TEST    = 4'd12,
		ENABLE_CAPTURE = 4'd13
	} cmd_op_e;

	// One serial byte as the host sends it
	typedef struct packed {
		logic [3:0] arg;                        // Byte bits 7:4
		logic [3:0] op;                         // Byte bits 3:0
	} cmd_byte_t;

endpackage

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
	import corr_cfg_pkg::*;
	import corr_cmd_pkg::*;
#(
	parameter int BASE_DIV = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      rx,
	input  code_t     baud_rate,
	output logic      rx_valid,
	output cmd_byte_t rx_byte
);
	localparam int CNT_W = $clog2(BASE_DIV) + 17;   // Room for BASE_DIV << 15

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_e;

	rx_state_e        state_q;
	logic             rx_meta_q;
	logic             rx_sync_q;
	logic             rx_prev_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] period_q;                     // Latched at each start bit
	logic [2:0]       bit_cnt_q;
	logic [7:0]       data_q;
	logic             start_edge;
	logic             half_hit;
	logic             full_hit;

	assign start_edge = (state_q == IDLE) && rx_prev_q && !rx_sync_q;
	assign half_hit   = cnt_q == (period_q >> 1) - 1'b1;
	assign full_hit   = cnt_q == period_q - 1'b1;

	// Line idles high, so the synchronizer comes out of reset high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta_q <= 1'b1;
			rx_sync_q <= 1'b1;
			rx_prev_q <= 1'b1;
		end else begin
			rx_meta_q <= rx;
			rx_sync_q <= rx_meta_q;
			rx_prev_q <= rx_sync_q;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q   <= IDLE;
			cnt_q     <= '0;
			bit_cnt_q <= '0;
			rx_valid  <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			cnt_q    <= cnt_q + 1'b1;
			case (state_q)
				IDLE: begin
					cnt_q <= '0;
					if (start_edge) begin
						state_q <= START;
					end
				end
				START: begin
					if (half_hit) begin
						cnt_q     <= '0;                 // Later samples fall mid-bit
						bit_cnt_q <= '0;
						state_q   <= rx_sync_q ? IDLE : DATA;   // Glitch, not a start bit
					end
				end
				DATA: begin
					if (full_hit) begin
						cnt_q     <= '0;
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == 3'd7) begin
							state_q <= STOP;
						end
					end
				end
				STOP: begin
					if (full_hit) begin
						rx_valid <= rx_sync_q;           // Low stop bit drops the frame
						state_q  <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_edge) begin
			period_q <= CNT_W'(BASE_DIV) << baud_rate;
		end
		if (state_q == DATA && full_hit) begin
			data_q <= {rx_sync_q, data_q[7:1]};   // LSB arrives first
		end
		if (state_q == STOP && full_hit && rx_sync_q) begin
			rx_byte <= cmd_byte_t'(data_q);
		end
	end

endmodule

// ==== hw/cmd_parser.sv ====
`timescale 1ns/1ps

module cmd_parser
	import corr_cfg_pkg::*;
	import corr_cmd_pkg::*;
#(
	parameter int NUM_INPUTS = 8,
	parameter int HAS_LEDS   = 1
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rx_valid,
	input  cmd_byte_t   rx_byte,
	output corr_flags_t flags,
	output lag_t        cross_idx [NUM_INPUTS],
	output lag_t        auto_idx  [NUM_INPUTS],
	output lag_t        cross_len [NUM_INPUTS],
	output lag_t        auto_len  [NUM_INPUTS],
	output nib8_t       test      [NUM_INPUTS],
	output nib8_t       leds      [NUM_INPUTS],
	output nib8_t       voltage   [NUM_INPUTS]
);
	localparam int SEL_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

	logic [SEL_W-1:0] sel;                          // Array slot of current line
	logic             line_ok;
	logic             is_delay;
	logic [3:0]       arg;
	logic [3:0]       lag_off;                      // Bit offset of the lag sub-field
	logic [2:0]       nib_off;                      // Bit offset of the nibble
	logic [2:0]       pair_off;                     // Bit offset of a 2-bit slot

	assign sel      = flags.current_line[SEL_W-1:0];
	assign line_ok  = int'(flags.current_line) < NUM_INPUTS;
	assign is_delay = rx_byte.op[3:2] == SET_DELAY[3:2];
	assign arg      = rx_byte.arg;
	assign lag_off  = 4'(rx_byte.op[1:0]) * 4'(LAG_SUB_W);
	assign nib_off  = flags.extra_commands ? 3'(NIB_W) : 3'd0;
	assign pair_off = {arg[3:2], 1'b0};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags                 <= '0;
			flags.timestamp_reset <= 1'b1;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				cross_idx[i] <= '0;
				auto_idx[i]  <= '0;
				cross_len[i] <= '0;
				auto_len[i]  <= '0;
				test[i]      <= '0;
				leds[i]      <= '0;
				voltage[i]   <= '0;
			end
		end else if (rx_valid) begin
			if (is_delay) begin
				// Bit 7 picks auto over cross, extra_commands the length bank
				if (line_ok) begin
					case ({flags.extra_commands, arg[3]})
						2'b00: cross_idx[sel][lag_off +: LAG_SUB_W] <= arg[2:0];
						2'b01: auto_idx[sel][lag_off +: LAG_SUB_W]  <= arg[2:0];
						2'b10: cross_len[sel][lag_off +: LAG_SUB_W] <= arg[2:0];
						default: auto_len[sel][lag_off +: LAG_SUB_W] <= arg[2:0];
					endcase
				end
			end else begin
				case (rx_byte.op)
					CLEAR: begin
						if (line_ok) begin
							cross_idx[sel] <= '0;       // Lengths are kept
							auto_idx[sel]  <= '0;
						end
					end
					SET_LINE: begin
						flags.current_line[pair_off +: 2] <= arg[1:0];
					end
					SET_LEDS: begin
						if (HAS_LEDS != 0 && line_ok) begin
							leds[sel][nib_off +: NIB_W] <= arg;
						end
					end
					SET_BAUD_RATE: begin
						flags.baud_rate <= arg;     // Receiver picks it up at next start bit
					end
					SET_FREQ_DIV: begin
						flags.clock_divider <= arg;
					end
					SET_VOLTAGE: begin
						if (line_ok) begin
							voltage[sel][pair_off +: 2] <= arg[1:0];
						end
					end
					ENABLE_TEST: begin
						if (line_ok) begin
							test[sel][nib_off +: NIB_W] <= arg;
						end
					end
					ENABLE_CAPTURE: begin
						flags.integrating     <= arg[0];
						flags.external_clock  <= arg[1];
						flags.timestamp_reset <= arg[2];
						flags.extra_commands  <= arg[3];
					end
					default: ;                      // Unused opcodes are ignored
				endcase
			end
		end
	end

endmodule

// ==== hw/bias_pwm.sv ====
`timescale 1ns/1ps

module bias_pwm
	import corr_cfg_pkg::*;
#(
	parameter int NUM_INPUTS = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  nib8_t                 voltage [NUM_INPUTS],
	output logic [NUM_INPUTS-1:0] bias
);
	logic [7:0] cnt_q;                              // Shared ramp, wraps every 256

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 8'd1;
		end
	end

	// Straight compare so a new code acts at once
	always_comb begin
		for (int i = 0; i < NUM_INPUTS; i++) begin
			bias[i] = cnt_q < voltage[i];           // Code 0 never high
		end
	end

endmodule

// ==== hw/corr_ctrl_top.sv ====
`timescale 1ns/1ps

module corr_ctrl_top
	import corr_cfg_pkg::*;
	import corr_cmd_pkg::*;
#(
	parameter int NUM_INPUTS = 8,
	parameter int HAS_LEDS   = 1,
	parameter int BASE_DIV   = 8
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rx,
	output corr_flags_t           flags,
	output lag_t                  cross_idx [NUM_INPUTS],
	output lag_t                  auto_idx  [NUM_INPUTS],
	output lag_t                  cross_len [NUM_INPUTS],
	output lag_t                  auto_len  [NUM_INPUTS],
	output nib8_t                 test      [NUM_INPUTS],
	output nib8_t                 leds      [NUM_INPUTS],
	output nib8_t                 voltage   [NUM_INPUTS],
	output logic [NUM_INPUTS-1:0] bias
);
	logic      rx_valid;
	cmd_byte_t rx_byte;

	uart_rx #(
		.BASE_DIV(BASE_DIV)
	) uart_rx_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx       (rx),
		.baud_rate(flags.baud_rate),           // Fed back from the parser
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	cmd_parser #(
		.NUM_INPUTS(NUM_INPUTS),
		.HAS_LEDS  (HAS_LEDS)
	) cmd_parser_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte),
		.flags    (flags),
		.cross_idx(cross_idx),
		.auto_idx (auto_idx),
		.cross_len(cross_len),
		.auto_len (auto_len),
		.test     (test),
		.leds     (leds),
		.voltage  (voltage)
	);

	bias_pwm #(
		.NUM_INPUTS(NUM_INPUTS)
	) bias_pwm_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.voltage(voltage),
		.bias   (bias)
	);

endmodule

// ==== verif/tb_corr_ctrl.sv ====
`timescale 1ns/1ps

module tb_corr_ctrl
	import corr_cfg_pkg::*;
	import corr_cmd_pkg::*;
();
	localparam int NUM_INPUTS   = 8;
	localparam int BASE_DIV     = 8;                 // Matches the DUT default
	localparam int SETTLE_LIMIT = 64;

	typedef enum logic [3:0] {
		F_CROSS_IDX, F_AUTO_IDX, F_BOTH_IDX, F_CROSS_LEN, F_AUTO_LEN, F_TEST,
		F_LEDS, F_VOLT, F_LINE, F_FLAGS, F_BAUD, F_DIV
	} field_e;

	// One row of the stimulus table
	typedef struct packed {
		logic [3:0]  arg;
		logic [3:0]  op;
		code_t       baud;                           // Code the frame is sent at
		logic        stop;                           // Stop bit level
		field_e      field;
		logic [2:0]  idx;
		logic [23:0] exp;
	} step_t;

	logic                  clk;
	logic                  rst_n;
	logic                  rx;
	corr_flags_t           flags;
	lag_t                  cross_idx [NUM_INPUTS];
	lag_t                  auto_idx  [NUM_INPUTS];
	lag_t                  cross_len [NUM_INPUTS];
	lag_t                  auto_len  [NUM_INPUTS];
	nib8_t                 test      [NUM_INPUTS];
	nib8_t                 leds      [NUM_INPUTS];
	nib8_t                 voltage   [NUM_INPUTS];
	logic [NUM_INPUTS-1:0] bias;

	string names[$];
	step_t steps[$];
	int    seed = 32'he6e4;
	int    test_errs;
	int    pass_cnt;
	int    fail_cnt;

	corr_ctrl_top dut_i (
		.clk(clk), .rst_n(rst_n), .rx(rx), .flags(flags),
		.cross_idx(cross_idx), .auto_idx(auto_idx), .cross_len(cross_len),
		.auto_len(auto_len), .test(test), .leds(leds), .voltage(voltage), .bias(bias)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic add_step(input string name, input logic [3:0] arg, input logic [3:0] op,
			input code_t baud, input logic stop, input field_e field, input int idx,
			input logic [23:0] exp);
		step_t s;
		s = '{arg: arg, op: op, baud: baud, stop: stop, field: field, idx: 3'(idx), exp: exp};
		names.push_back(name);
		steps.push_back(s);
	endtask

	function automatic logic [23:0] read_field(input field_e f, input int idx);
		case (f)
			F_CROSS_IDX: return 24'(cross_idx[idx]);
			F_AUTO_IDX:  return 24'(auto_idx[idx]);
			F_BOTH_IDX:  return {cross_idx[idx], auto_idx[idx]};
			F_CROSS_LEN: return 24'(cross_len[idx]);
			F_AUTO_LEN:  return 24'(auto_len[idx]);
			F_TEST:      return 24'(test[idx]);
			F_LEDS:      return 24'(leds[idx]);
			F_VOLT:      return 24'(voltage[idx]);
			F_LINE:      return 24'(flags.current_line);
			F_FLAGS:     return 24'({flags.integrating, flags.external_clock,
					flags.timestamp_reset, flags.extra_commands});
			F_BAUD:      return 24'(flags.baud_rate);
			default:     return 24'(flags.clock_divider);
		endcase
	endfunction

	task automatic hold_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Start bit, eight data bits LSB first, stop bit, then idle high
	task automatic send_frame(input cmd_byte_t data, input code_t baud, input logic stop);
		int period;
		logic [7:0] bits;
		period = BASE_DIV << baud;
		bits   = data;
		rx     = 1'b0;
		hold_cycles(period);
		for (int i = 0; i < 8; i++) begin
			rx = bits[i];
			hold_cycles(period);
		end
		rx = stop;
		hold_cycles(period);
		rx = 1'b1;
		hold_cycles(4);
	endtask

	task automatic check_value(input string name, input logic [23:0] exp, input logic [23:0] act);
		assert (act == exp) else begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("pass %s", name);
		end else begin
			fail_cnt++;
			$display("FAIL %s", name);
		end
		test_errs = 0;
	endtask

	// Counts high cycles of one bias output over a full PWM period
	task automatic count_bias(input int idx, output int highs);
		highs = 0;
		repeat (256) begin
			@(negedge clk);
			if (bias[idx]) highs++;
		end
	endtask

	task automatic check_reset();
		corr_flags_t exp_flags;
		int highs;
		exp_flags                 = '0;
		exp_flags.timestamp_reset = 1'b1;
		check_value("reset_values", 24'(exp_flags), 24'(flags));
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int f = F_CROSS_IDX; f <= F_VOLT; f++) begin
				check_value("reset_values", 24'd0, read_field(field_e'(f), i));
			end
			count_bias(i, highs);
			check_value("reset_values", 24'd0, 24'(highs));
		end
		finish_test("reset_values");
	endtask

	initial begin
		step_t s;
		cmd_byte_t cmd;
		logic [23:0] act;
		int n;
		int gap;
		int highs;
		rx    = 1'b1;
		rst_n = 1'b0;
		test_errs = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		add_step("line_slot0", 4'h1, SET_LINE, 0, 1, F_LINE, 0, 24'h01);
		add_step("line_slot1", 4'h5, SET_LINE, 0, 1, F_LINE, 0, 24'h05);
		add_step("cross_idx_sub1", 4'h3, SET_DELAY | 4'd1, 0, 1, F_CROSS_IDX, 5, 24'h018);
		add_step("auto_idx_sub2", 4'hE, SET_DELAY | 4'd2, 0, 1, F_AUTO_IDX, 5, 24'h180);
		add_step("input0_kept", 4'h9, SET_DELAY | 4'd3, 0, 1, F_BOTH_IDX, 0, 24'h0);
		add_step("clear_line5", 4'h0, CLEAR, 0, 1, F_BOTH_IDX, 5, 24'h0);
		add_step("capture_flags", 4'hF, ENABLE_CAPTURE, 0, 1, F_FLAGS, 0, 24'hF);
		add_step("cross_len_sub0", 4'h5, SET_DELAY, 0, 1, F_CROSS_LEN, 5, 24'h005);
		add_step("auto_len_sub1", 4'hA, SET_DELAY | 4'd1, 0, 1, F_AUTO_LEN, 5, 24'h010);
		add_step("leds_upper", 4'hA, SET_LEDS, 0, 1, F_LEDS, 5, 24'hA0);
		add_step("test_upper", 4'h7, ENABLE_TEST, 0, 1, F_TEST, 5, 24'h70);
		add_step("baud_code1", 4'h1, SET_BAUD_RATE, 0, 1, F_BAUD, 0, 24'h1);
		add_step("freq_div_slow", 4'h9, SET_FREQ_DIV, 1, 1, F_DIV, 0, 24'h9);
		add_step("volt_slot0", 4'h2, SET_VOLTAGE, 1, 1, F_VOLT, 5, 24'h02);
		add_step("volt_slot1", 4'h5, SET_VOLTAGE, 1, 1, F_VOLT, 5, 24'h06);
		add_step("volt_slot2", 4'hB, SET_VOLTAGE, 1, 1, F_VOLT, 5, 24'h36);
		add_step("volt_slot3", 4'hE, SET_VOLTAGE, 1, 1, F_VOLT, 5, 24'hB6);
		add_step("bad_stop_bit", 4'h3, SET_FREQ_DIV, 1, 0, F_DIV, 0, 24'h9);
		add_step("good_after_bad", 4'h3, SET_FREQ_DIV, 1, 1, F_DIV, 0, 24'h3);
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_reset();
		for (int t = 0; t < steps.size(); t++) begin
			s       = steps[t];
			cmd.arg = s.arg;
			cmd.op  = s.op;
			gap     = 4 + ($random(seed) & 32'hF);   // Idle line between frames
			hold_cycles(gap);
			send_frame(cmd, s.baud, s.stop);
			n   = 0;
			act = read_field(s.field, int'(s.idx));
			while (act != s.exp && n < SETTLE_LIMIT) begin
				@(negedge clk);
				act = read_field(s.field, int'(s.idx));
				n++;
			end
			check_value(names[t], s.exp, act);
			finish_test(names[t]);
		end
		count_bias(5, highs);                       // Code B6 gives 182 of 256
		check_value("pwm_duty", 24'd182, 24'(highs));
		finish_test("pwm_duty");
		$display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
hw/corr_cfg_pkg.sv
hw/corr_cmd_pkg.sv
hw/uart_rx.sv
hw/cmd_parser.sv
hw/bias_pwm.sv
hw/corr_ctrl_top.sv
verif/tb_corr_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_corr_ctrl -f flist.f \
	-o sim_corr_ctrl > build.log 2>&1 &&
	./obj_dir/sim_corr_ctrl > sim.log 2>&1
grep -qx "All checks passed" sim.log && echo "PASS" || {
	echo "FAIL (see build.log and sim.log)"
	exit 1
}
